// File: axi_write_master.f
+incdir+design
design/axi_wr_pkg.sv
design/xfer_setup_if.sv
design/xfer_counter.sv
design/xfer_setup.sv
design/wdata_channel.sv
design/waddr_channel.sv
design/wresp_tracker.sv
design/axi_write_master.sv
testbench/axi_mem_slave_model.sv
testbench/tb_axi_write_master.sv

// File: Bender.yml
package:
  name: axi_write_master

sources:
  - include_dirs:
      - design
    files:
      - design/axi_wr_pkg.sv
      - design/xfer_setup_if.sv
      - design/xfer_counter.sv
      - design/xfer_setup.sv
      - design/wdata_channel.sv
      - design/waddr_channel.sv
      - design/wresp_tracker.sv
      - design/axi_write_master.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/axi_mem_slave_model.sv
      - testbench/tb_axi_write_master.sv

// File: testbench/tb_axi_write_master.sv
`timescale 1ns/1ps

`include "axi_wr_defines.svh"

module tb_axi_write_master;
  import axi_wr_pkg::*;

  // Words of all tests: 1 + 258 + 1024 + 2251
  localparam int TOTAL_WORDS = 3534;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_WORDS + 2000;

  logic aclk = 1'b0;
  logic areset = 1'b1;
  logic ctrl_start = 1'b0;
  logic ctrl_done;
  addr_t ctrl_addr_offset = '0;
  size_t ctrl_xfer_size_in_bytes = '0;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  addr_t awaddr;
  awlen_t awlen;
  data_t wdata;
  strb_t wstrb;
  logic tvalid = 1'b0;
  logic tready;
  data_t tdata = '0;
  logic hold_resp = 1'b0;
  logic started = 1'b0;

  integer seed = 8310;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  // Expected shape of the running transfer
  int exp_words, exp_bursts;
  strb_t exp_final_strb;

  // Monitor state
  data_t exp_word = '0;
  int beat = 0;
  int w_burst = 0;
  int aw_total = 0;
  int b_total = 0;
  int b_test = 0;
  int done_count = 0;
  int max_outstanding = 0;
  logic done_exp = 1'b0;

  always #5 aclk = ~aclk;

  axi_write_master dut_i (
    .aclk (aclk), .areset (areset),
    .ctrl_start (ctrl_start), .ctrl_done (ctrl_done),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .m_axi_awvalid (awvalid), .m_axi_awready (awready),
    .m_axi_awaddr (awaddr), .m_axi_awlen (awlen),
    .m_axi_wvalid (wvalid), .m_axi_wready (wready), .m_axi_wdata (wdata),
    .m_axi_wstrb (wstrb), .m_axi_wlast (wlast),
    .m_axi_bvalid (bvalid), .m_axi_bready (bready),
    .s_axis_tvalid (tvalid), .s_axis_tready (tready), .s_axis_tdata (tdata)
  );

  axi_mem_slave_model #(.SEED (8310)) slave_i (
    .aclk (aclk), .areset (areset), .hold_resp (hold_resp),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
    .wvalid (wvalid), .wready (wready), .wstrb (wstrb),
    .wlast (wlast), .bvalid (bvalid), .bready (bready)
  );

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Beats minus one of burst b in the running transfer
  function automatic int burst_len(int b);
    return (b < exp_bursts - 1) ? 255 : (exp_words - 1) % 256;
  endfunction

  ////////////////////
  // Stimulus stream
  ////////////////////

  // Incrementing words, tvalid only changes once the word is gone
  always @(posedge aclk) begin
    if (!areset) begin
      if (tvalid && tready) begin
        tdata <= tdata + 1'b1;
      end
      if (!tvalid || tready) begin
        tvalid <= $random(seed) % 2 != 0;
      end
    end
  end

  ////////////////////
  // Monitors
  ////////////////////

  // W beats: order and burst edges
  always @(posedge aclk) begin
    logic exp_last;
    if (!areset && wvalid && wready) begin
      exp_last = (beat == burst_len(w_burst));
      check_value("m_axi_wdata", exp_word, wdata);
      check_value("m_axi_wlast", 32'(exp_last), 32'(wlast));
      exp_word <= exp_word + 1'b1;
      if (exp_last) begin
        beat <= 0;
        w_burst <= w_burst + 1;
      end else begin
        beat <= beat + 1;
      end
    end
  end

  // Outstanding count and done timing
  always @(posedge aclk) begin
    if (!areset) begin
      check_value("ctrl_done", 32'(done_exp), 32'(ctrl_done));
      if (ctrl_done) begin
        done_count <= done_count + 1;
      end
      if (awvalid && awready) begin
        aw_total <= aw_total + 1;
      end
      if (aw_total - b_total > max_outstanding) begin
        max_outstanding <= aw_total - b_total;
      end
      done_exp <= 1'b0;
      if (bvalid && bready) begin
        b_total <= b_total + 1;
        b_test <= b_test + 1;
        done_exp <= (b_test == exp_bursts - 1);
      end
    end
  end

  a_reset_quiet: assert property (
    @(posedge aclk) disable iff (areset)
    !started |-> !awvalid && !wvalid && !tready && !ctrl_done
  ) else begin
    $display("Bus active at %0t before the first start", $time);
    errors++;
  end

  a_outstanding_limit: assert property (
    @(posedge aclk) disable iff (areset)
    aw_total - b_total <= `AXI_WR_MAX_OUTSTANDING
  ) else begin
    $display("Too many addresses without a response at %0t", $time);
    errors++;
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic run_test(addr_t offset, int size, bit force_stall);
    int err_start;
    int aw_first;
    int beat_first;
    int rem;
    addr_t base;
    err_start = errors;
    aw_first = slave_i.aw_addr_q.size();
    beat_first = slave_i.w_beats;
    rem = size % 4;
    base = offset & ~addr_t'(32'hfff);
    @(posedge aclk);
    exp_words <= (size + 3) / 4;
    exp_bursts <= ((size + 3) / 4 + 255) / 256;
    exp_final_strb <= (rem == 0) ? 4'hf : strb_t'((1 << rem) - 1);
    beat <= 0;
    w_burst <= 0;
    b_test <= 0;
    done_count <= 0;
    hold_resp <= force_stall;
    ctrl_start <= 1'b1;
    started <= 1'b1;
    ctrl_addr_offset <= offset;
    ctrl_xfer_size_in_bytes <= size_t'(size);
    @(posedge aclk);
    ctrl_start <= 1'b0;
    if (force_stall) begin
      // Hold responses until the master runs out of slots
      while (aw_total - b_total < `AXI_WR_MAX_OUTSTANDING) @(posedge aclk);
      repeat (10) @(posedge aclk);
      hold_resp <= 1'b0;
    end
    while (!ctrl_done) @(posedge aclk);
    repeat (30) @(posedge aclk);
    // End-of-test compares against the slave log
    check_value("address count", exp_bursts, slave_i.aw_addr_q.size() - aw_first);
    for (int n = 0; n < exp_bursts && aw_first + n < slave_i.aw_addr_q.size(); n++) begin
      check_value("m_axi_awaddr", base + 32'(n) * 32'd4096, slave_i.aw_addr_q[aw_first + n]);
      check_value("m_axi_awlen", burst_len(n), 32'(slave_i.aw_len_q[aw_first + n]));
    end
    check_value("beat count", exp_words, slave_i.w_beats - beat_first);
    // Full lanes everywhere but the closing beat
    for (int k = 0; k < exp_words && beat_first + k < slave_i.w_strb_q.size(); k++) begin
      check_value("m_axi_wstrb", (k == exp_words - 1) ? 32'(exp_final_strb) : 32'hf,
                  32'(slave_i.w_strb_q[beat_first + k]));
    end
    check_value("response count", exp_bursts, b_test);
    check_value("ctrl_done pulses", 1, done_count);
    if (force_stall && max_outstanding < `AXI_WR_MAX_OUTSTANDING) begin
      $display("Outstanding limit was never reached, no stall happened");
      errors++;
    end
    tests_run++;
    if (errors != err_start) begin
      tests_failed++;
    end
    $display("Test %0d: %0d bytes at %h %s", tests_run, size, offset,
             (errors == err_start) ? "passed" : "failed");
  endtask

  initial begin
    repeat (16) @(posedge aclk);
    areset <= 1'b0;
    repeat (20) @(posedge aclk);
    run_test(32'h0000_0000, 4, 1'b0);
    run_test(32'h0004_0000, 1030, 1'b0);
    run_test(32'h0010_0000, 4096, 1'b0);
    run_test(32'h0001_2345, 9001, 1'b1);
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the words of all tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Watchdog expired, the transfers did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: testbench/axi_mem_slave_model.sv
`timescale 1ns/1ps

module axi_mem_slave_model
  import axi_wr_pkg::*;
#(
  parameter int SEED = 8310
) (
  input  logic   aclk,
  input  logic   areset,
  input  logic   hold_resp,
  input  logic   awvalid,
  output logic   awready,
  input  addr_t  awaddr,
  input  awlen_t awlen,
  input  logic   wvalid,
  output logic   wready,
  input  strb_t  wstrb,
  input  logic   wlast,
  output logic   bvalid,
  input  logic   bready
);

  integer seed = SEED;

  // Log of everything accepted, read by the testbench
  addr_t  aw_addr_q[$];
  awlen_t aw_len_q[$];
  strb_t  w_strb_q[$];
  int     w_beats = 0;

  // Per-burst response delays, oldest first
  int delay_q[$];
  int aw_count = 0;
  int resp_issued = 0;

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
  end

  always @(posedge aclk) begin
    if (areset) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      // Ready about three cycles in four
      awready <= ($random(seed) % 4) != 0;
      wready  <= ($random(seed) % 4) != 0;
      if (awvalid && awready) begin
        aw_addr_q.push_back(awaddr);
        aw_len_q.push_back(awlen);
        aw_count++;
      end
      if (wvalid && wready) begin
        w_beats++;
        w_strb_q.push_back(wstrb);
        if (wlast) begin
          delay_q.push_back($unsigned($random(seed)) % 21);
        end
      end
      // In order, and never ahead of the burst's address
      // A raised response waits for bready
      if (!bvalid || bready) begin
        bvalid <= 1'b0;
        if (!hold_resp && delay_q.size() > 0 && aw_count > resp_issued) begin
          if (delay_q[0] == 0) begin
            void'(delay_q.pop_front());
            bvalid <= 1'b1;
            resp_issued++;
          end else begin
            delay_q[0] = delay_q[0] - 1;
          end
        end
      end
    end
  end

endmodule

// File: design/axi_write_master.sv
`timescale 1ns/1ps

module axi_write_master
  import axi_wr_pkg::*;
(
  input  logic   aclk,
  input  logic   areset,

  // Control
  input  logic   ctrl_start,
  output logic   ctrl_done,
  input  addr_t  ctrl_addr_offset,
  input  size_t  ctrl_xfer_size_in_bytes,

  // AXI4 write address
  output logic   m_axi_awvalid,
  input  logic   m_axi_awready,
  output addr_t  m_axi_awaddr,
  output awlen_t m_axi_awlen,

  // AXI4 write data
  output logic   m_axi_wvalid,
  input  logic   m_axi_wready,
  output data_t  m_axi_wdata,
  output strb_t  m_axi_wstrb,
  output logic   m_axi_wlast,

  // AXI4 write response
  input  logic   m_axi_bvalid,
  output logic   m_axi_bready,

  // Stream in, same clock as the bus
  input  logic   s_axis_tvalid,
  output logic   s_axis_tready,
  input  data_t  s_axis_tdata
);

  // W to AW, first beat of each burst
  logic burst_first;
  // AW to B, address taken and slot check
  logic aw_accept;
  logic aw_stall;

  xfer_setup_if setup_if ();

  ////////////////////
  // Request and channels
  ////////////////////

  xfer_setup setup_i (
    .aclk                    (aclk),
    .areset                  (areset),
    .ctrl_start              (ctrl_start),
    .ctrl_addr_offset        (ctrl_addr_offset),
    .ctrl_xfer_size_in_bytes (ctrl_xfer_size_in_bytes),
    .setup                   (setup_if.setup)
  );

  wdata_channel wdata_i (
    .aclk          (aclk),
    .areset        (areset),
    .setup         (setup_if.chan),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tready (s_axis_tready),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .burst_first   (burst_first)
  );

  waddr_channel waddr_i (
    .aclk          (aclk),
    .areset        (areset),
    .setup         (setup_if.chan),
    .burst_first   (burst_first),
    .aw_stall      (aw_stall),
    .aw_accept     (aw_accept),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen)
  );

  wresp_tracker wresp_i (
    .aclk         (aclk),
    .areset       (areset),
    .setup        (setup_if.chan),
    .aw_accept    (aw_accept),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

// File: design/wresp_tracker.sv
`timescale 1ns/1ps

`include "axi_wr_defines.svh"

module wresp_tracker
  import axi_wr_pkg::*;
(
  input  logic aclk,
  input  logic areset,
  xfer_setup_if.chan setup,
  input  logic aw_accept,
  input  logic m_axi_bvalid,
  output logic m_axi_bready,
  output logic aw_stall,
  output logic ctrl_done
);

  logic     bxfer;
  logic     final_resp;
  vacancy_t vacancy;

  // Responses always taken
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;

  // Responses still owed for this transfer
  xfer_counter #(
    .count_t    (txn_cnt_t),
    .init_value (txn_cnt_t'(0))
  ) resp_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (setup.start),
    .incr       (1'b0),
    .decr       (bxfer),
    .load_value (setup.num_txn),
    .count      (),
    .is_zero    (final_resp)
  );

  // Free slots, an address takes one and its response gives it back
  xfer_counter #(
    .count_t    (vacancy_t),
    .init_value (vacancy_t'(`AXI_WR_MAX_OUTSTANDING))
  ) vacancy_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (aw_accept),
    .load_value (vacancy_t'(0)),
    .count      (vacancy),
    .is_zero    (aw_stall)
  );

  // Done one cycle behind the closing response
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= bxfer & final_resp;
    end
  end

  // A response with every slot free has no address behind it
  a_no_orphan_resp: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_bvalid |-> vacancy != vacancy_t'(`AXI_WR_MAX_OUTSTANDING)
  );

endmodule

// File: design/waddr_channel.sv
`timescale 1ns/1ps

module waddr_channel
  import axi_wr_pkg::*;
(
  input  logic   aclk,
  input  logic   areset,
  xfer_setup_if.chan setup,
  input  logic   burst_first,
  input  logic   aw_stall,
  output logic   aw_accept,
  output logic   m_axi_awvalid,
  input  logic   m_axi_awready,
  output addr_t  m_axi_awaddr,
  output awlen_t m_axi_awlen
);

  // Length field of a full burst
  localparam awlen_t FULL_LEN = awlen_t'(BURST_BEATS - 1);

  logic awvalid_r;
  logic no_pending;
  logic final_addr;

  assign m_axi_awvalid = awvalid_r;
  assign aw_accept     = awvalid_r & m_axi_awready;

  ////////////////////
  // Burst bookkeeping
  ////////////////////

  // Bursts whose data has started but whose address is not out yet
  xfer_counter #(
    .count_t    (txn_cnt_t),
    .init_value (txn_cnt_t'(0))
  ) pending_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_first),
    .decr       (aw_accept),
    .load_value (txn_cnt_t'(0)),
    .count      (),
    .is_zero    (no_pending)
  );

  // Addresses left in this transfer, zero flag marks the last one
  xfer_counter #(
    .count_t    (txn_cnt_t),
    .init_value (txn_cnt_t'(0))
  ) addr_left_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (setup.start),
    .incr       (1'b0),
    .decr       (aw_accept),
    .load_value (setup.num_txn),
    .count      (),
    .is_zero    (final_addr)
  );

  ////////////////////
  // AW handshake
  ////////////////////

  // Raise only with data on its way and a free slot, drop after ready
  always_ff @(posedge aclk) begin
    if (areset) begin
      awvalid_r <= 1'b0;
    end else if (!awvalid_r) begin
      awvalid_r <= !no_pending && !aw_stall;
    end else if (m_axi_awready) begin
      awvalid_r <= 1'b0;
    end
  end

  // Next page on each accepted address
  always_ff @(posedge aclk) begin
    if (setup.start) begin
      m_axi_awaddr <= setup.base_addr;
    end else if (aw_accept) begin
      m_axi_awaddr <= m_axi_awaddr + addr_t'(BURST_BYTES);
    end
  end

  assign m_axi_awlen = final_addr ? awlen_t'(setup.final_len) : FULL_LEN;

  // An address never goes out without a free outstanding slot
  a_aw_has_slot: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_awvalid |-> !aw_stall
  );

  a_aw_payload_stable: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=>
      $stable(m_axi_awaddr) && $stable(m_axi_awlen)
  );

endmodule

// File: design/wdata_channel.sv
`timescale 1ns/1ps

module wdata_channel
  import axi_wr_pkg::*;
(
  input  logic  aclk,
  input  logic  areset,
  xfer_setup_if.chan setup,
  input  logic  s_axis_tvalid,
  input  data_t s_axis_tdata,
  output logic  s_axis_tready,
  output logic  m_axi_wvalid,
  input  logic  m_axi_wready,
  output data_t m_axi_wdata,
  output strb_t m_axi_wstrb,
  output logic  m_axi_wlast,
  output logic  burst_first
);

  logic     running;
  logic     wxfer;
  logic     final_txn;
  logic     almost_final_txn;
  logic     final_beat;
  logic     load_beats;
  txn_cnt_t txn_left;
  logic     wfirst;
  logic     first_seen;
  logic     first_pending;

  ////////////////////
  // Stream to W
  ////////////////////

  // Nothing moves until the transfer has been set up
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign s_axis_tready = m_axi_wready & running;
  assign m_axi_wdata   = s_axis_tdata;

  assign wxfer      = m_axi_wvalid & m_axi_wready;
  assign final_beat = wxfer & m_axi_wlast & final_txn;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (setup.start) begin
      running <= 1'b1;
    end else if (final_beat) begin
      running <= 1'b0;
    end
  end

  // Short strobe only on the closing beat of the transfer
  assign m_axi_wstrb = (m_axi_wlast && final_txn) ? setup.final_strb : '1;

  ////////////////////
  // Beat and burst counting
  ////////////////////

  // Last burst gets the short length, loaded as the one before it closes
  assign almost_final_txn = (txn_left == txn_cnt_t'(1));
  assign load_beats = (wxfer & m_axi_wlast & almost_final_txn) |
                      (setup.start & setup.single_txn);

  // Idles at all ones, wraps back there after each burst
  xfer_counter #(
    .count_t    (beat_cnt_t),
    .init_value (beat_cnt_t'('1))
  ) beat_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (setup.final_len),
    .count      (),
    .is_zero    (m_axi_wlast)
  );

  // Bursts still to close on W
  xfer_counter #(
    .count_t    (txn_cnt_t),
    .init_value (txn_cnt_t'(0))
  ) burst_cnt_i (
    .aclk       (aclk),
    .areset     (areset),
    .load       (setup.start),
    .incr       (1'b0),
    .decr       (wxfer & m_axi_wlast),
    .load_value (setup.num_txn),
    .count      (txn_left),
    .is_zero    (final_txn)
  );

  ////////////////////
  // First beat detect
  ////////////////////

  // wfirst marks that the next beat opens a burst
  // first_seen keeps a stalled first beat from announcing itself twice
  assign first_pending = m_axi_wvalid & wfirst & ~first_seen;

  always_ff @(posedge aclk) begin
    if (areset) begin
      wfirst      <= 1'b1;
      first_seen  <= 1'b0;
      burst_first <= 1'b0;
    end else begin
      burst_first <= first_pending;
      if (wxfer) begin
        wfirst <= m_axi_wlast;
      end
      if (wxfer && m_axi_wlast) begin
        first_seen <= 1'b0;
      end else if (first_pending) begin
        first_seen <= 1'b1;
      end
    end
  end

  // A new transfer only lands once the previous one has drained from W
  a_start_when_idle: assert property (
    @(posedge aclk) disable iff (areset)
    setup.start |-> !running
  );

endmodule

// File: design/xfer_setup.sv
`timescale 1ns/1ps

module xfer_setup
  import axi_wr_pkg::*;
(
  input  logic  aclk,
  input  logic  areset,
  input  logic  ctrl_start,
  input  addr_t ctrl_addr_offset,
  input  size_t ctrl_xfer_size_in_bytes,
  xfer_setup_if.setup setup
);

  // Low address bits cleared so the first burst starts on a page
  localparam addr_t ADDR_MASK = addr_t'(BURST_BYTES - 1);

  addr_t                   base_addr_r;
  logic [WORDS_W-1:0]      total_len_r;
  logic [LOG_DW_BYTES-1:0] byte_rem_r;
  logic [WORDS_W-1:0]      size_words;
  logic [LOG_DW_BYTES-1:0] size_rem;
  logic                    start_d1;

  // Split the byte count into whole words and leftover bytes
  assign size_words = ctrl_xfer_size_in_bytes[LOG_DW_BYTES +: WORDS_W];
  assign size_rem   = ctrl_xfer_size_in_bytes[0 +: LOG_DW_BYTES];

  ////////////////////
  // Request capture
  ////////////////////

  // Word count rounded up, kept in length-minus-one form
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      base_addr_r <= ctrl_addr_offset & ~ADDR_MASK;
      total_len_r <= (size_rem != '0) ? size_words : size_words - 1'b1;
      byte_rem_r  <= size_rem;
    end
  end

  ////////////////////
  // Derived fields
  ////////////////////

  // Upper bits count bursts, lower bits are the length of the last one
  assign setup.base_addr  = base_addr_r;
  assign setup.num_txn    = total_len_r[LOG_BURST_BEATS +: TXN_W];
  assign setup.final_len  = total_len_r[0 +: LOG_BURST_BEATS];
  assign setup.single_txn = (setup.num_txn == '0);

  // Partial last word keeps only the low lanes, a full one keeps all
  always_ff @(posedge aclk) begin
    for (int i = 0; i < DW_BYTES; i++) begin
      setup.final_strb[i] <= (byte_rem_r == '0) || (i < byte_rem_r);
    end
  end

  // Start fires two cycles after the request
  // by then every field above has settled
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1    <= 1'b0;
      setup.start <= 1'b0;
    end else begin
      start_d1    <= ctrl_start;
      setup.start <= start_d1;
    end
  end

endmodule

// File: design/xfer_counter.sv
`timescale 1ns/1ps

module xfer_counter
  import axi_wr_pkg::*;
#(
  parameter type count_t = beat_cnt_t,
  parameter count_t init_value = '0
) (
  input  logic   aclk,
  input  logic   areset,
  input  logic   load,
  input  logic   incr,
  input  logic   decr,
  input  count_t load_value,
  output count_t count,
  output logic   is_zero
);

  count_t count_next;

  // Load first, then a single step
  // Simultaneous up and down leave the value alone
  always_comb begin
    count_next = count;
    if (load) begin
      count_next = load_value;
    end else if (incr && !decr) begin
      count_next = count_t'(count + 1'b1);
    end else if (decr && !incr) begin
      count_next = count_t'(count - 1'b1);
    end
  end

  // Zero flag comes out of a flop next to the count
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= init_value;
      is_zero <= (init_value == count_t'(0));
    end else begin
      count <= count_next;
      is_zero <= (count_next == count_t'(0));
    end
  end

endmodule

// File: design/xfer_setup_if.sv
`timescale 1ns/1ps

interface xfer_setup_if
  import axi_wr_pkg::*;
();

  // One-cycle kick for all three channels
  logic start;
  // Page-aligned first burst address
  addr_t base_addr;
  // Bursts in the transfer, minus one
  txn_cnt_t num_txn;
  // Beats in the last burst, minus one
  beat_cnt_t final_len;
  // Whole transfer fits in one burst
  logic single_txn;
  // Byte lanes of the very last beat
  strb_t final_strb;

  // Request side
  modport setup (
    output start, base_addr, num_txn, final_len, single_txn, final_strb
  );

  // Channel side, fields held steady until the next request
  modport chan (
    input start, base_addr, num_txn, final_len, single_txn, final_strb
  );

endinterface

// File: design/axi_wr_pkg.sv
`include "axi_wr_defines.svh"

package axi_wr_pkg;

  // Bytes per data word and the address bits that select a byte
  localparam int DW_BYTES = `AXI_WR_DATA_W / 8;
  localparam int LOG_DW_BYTES = $clog2(DW_BYTES);

  // Beats per full burst, bounded by both the page and the protocol
  localparam int BURST_BEATS =
    ((`AXI_WR_MAX_BURST_BYTES / DW_BYTES) < `AXI_WR_MAX_BURST_BEATS) ?
    (`AXI_WR_MAX_BURST_BYTES / DW_BYTES) : `AXI_WR_MAX_BURST_BEATS;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);

  // Address step from one burst to the next, also the alignment unit
  localparam int BURST_BYTES = `AXI_WR_MAX_BURST_BYTES;

  // Word count and burst count widths of a request
  localparam int WORDS_W = `AXI_WR_SIZE_W - LOG_DW_BYTES;
  localparam int TXN_W = WORDS_W - LOG_BURST_BEATS;
  localparam int VACANCY_W = $clog2(`AXI_WR_MAX_OUTSTANDING + 1);

  typedef logic [`AXI_WR_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_WR_DATA_W-1:0] data_t;
  typedef logic [DW_BYTES-1:0] strb_t;
  typedef logic [`AXI_WR_SIZE_W-1:0] size_t;
  typedef logic [$clog2(`AXI_WR_MAX_BURST_BEATS)-1:0] awlen_t;
  typedef logic [LOG_BURST_BEATS-1:0] beat_cnt_t;
  typedef logic [TXN_W-1:0] txn_cnt_t;
  typedef logic [VACANCY_W-1:0] vacancy_t;

endpackage

// File: design/axi_wr_defines.svh
`ifndef AXI_WR_DEFINES_SVH
`define AXI_WR_DEFINES_SVH

// Bus widths
`define AXI_WR_ADDR_W 32
`define AXI_WR_DATA_W 32

// Width of the byte count taken with a request
`define AXI_WR_SIZE_W 20

////////////////////
// Protocol burst limits
////////////////////

// Longest INCR burst in beats
`define AXI_WR_MAX_BURST_BEATS 256
// A burst never crosses a 4 KB page
`define AXI_WR_MAX_BURST_BYTES 4096

// Addresses allowed in flight without a response
`define AXI_WR_MAX_OUTSTANDING 4

`endif
